// ==== src/vmul_pkg.sv ====
package vmul_pkg;

	// operand and result width
	localparam int data_width = 64;

	// one sub-multiplier input slice
	localparam int chunk_width = 16;
	localparam int num_chunks = data_width / chunk_width;

	// byte lanes are handled by their own 8x8 multipliers
	localparam int byte_width = 8;
	localparam int byte_lanes = data_width / byte_width;

	// one packed lane in 32-bit mode
	localparam int word_width = 32;

	// widths of a chunk product and of a column sum
	localparam int chunk_prod_width = 2 * chunk_width;

	// four 32-bit products fit in 34 bits
	localparam int col_sum_width = chunk_prod_width + 2;

	// cycles from start to result_valid
	localparam int latency = 3;

	// lane size selection
	typedef enum logic [1:0]
	{
		lane8  = 2'd0,
		lane16 = 2'd1,
		lane32 = 2'd2,
		lane64 = 2'd3
	} lane_size_t;

	// one zero-extended 16x16 product
	typedef logic [chunk_prod_width-1:0] chunk_prod_t;

	// sum of the chunk products of one column weight
	typedef logic [col_sum_width-1:0] col_sum_t;

endpackage

// ==== src/partial_product_stage.sv ====
`timescale 1ns/1ps

module partial_product_stage
	import vmul_pkg::*;
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic                                         start,
	input  logic [data_width-1:0]                        a,
	input  logic [data_width-1:0]                        b,
	input  lane_size_t                                   lane_size,
	output logic                                         pp_valid,
	output lane_size_t                                   pp_lane_size,
	output chunk_prod_t [num_chunks-1:0][num_chunks-1:0] chunk_prod,
	output logic [byte_lanes-1:0][byte_width-1:0]        byte_prod
);

	// operands viewed as 16-bit chunks
	logic [num_chunks-1:0][chunk_width-1:0] a_chunk;
	logic [num_chunks-1:0][chunk_width-1:0] b_chunk;

	// operands viewed as bytes
	logic [byte_lanes-1:0][byte_width-1:0] a_byte;
	logic [byte_lanes-1:0][byte_width-1:0] b_byte;

	// products before the stage register
	chunk_prod_t [num_chunks-1:0][num_chunks-1:0] chunk_prod_next;
	logic [byte_lanes-1:0][byte_width-1:0]        byte_prod_next;

	assign a_chunk = a;
	assign b_chunk = b;
	assign a_byte = a;
	assign b_byte = b;

	// all sixteen chunk products
	// first index is the a chunk, second is the b chunk
	always_comb
	begin
		for (int i = 0; i < num_chunks; i++)
		begin
			for (int j = 0; j < num_chunks; j++)
			begin
				chunk_prod_next[i][j] = chunk_prod_t'(a_chunk[i])
					* chunk_prod_t'(b_chunk[j]);
			end
		end
	end

	// byte lanes keep only the low 8 bits of each product
	always_comb
	begin
		for (int k = 0; k < byte_lanes; k++)
		begin
			byte_prod_next[k] = a_byte[k] * b_byte[k];
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pp_valid <= 1'b0;
		end
		else
		begin
			pp_valid <= start;
		end
	end

	// payload only moves when an operation is issued
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			pp_lane_size <= lane_size;
			chunk_prod <= chunk_prod_next;
			byte_prod <= byte_prod_next;
		end
	end

endmodule

// ==== src/column_sum_stage.sv ====
`timescale 1ns/1ps

module column_sum_stage
	import vmul_pkg::*;
(
	input  logic                                         clk,
	input  logic                                         arst_n,
	input  logic                                         pp_valid,
	input  lane_size_t                                   pp_lane_size,
	input  chunk_prod_t [num_chunks-1:0][num_chunks-1:0] chunk_prod,
	input  logic [byte_lanes-1:0][byte_width-1:0]        byte_prod,
	output logic                                         cs_valid,
	output lane_size_t                                   cs_lane_size,
	output col_sum_t [num_chunks-1:0]                    col_sum,
	output logic [data_width-1:0]                        low_word
);

	col_sum_t [num_chunks-1:0] col_sum_next;
	logic [data_width-1:0]     low_word_next;

	// column sums and packed words for each lane size
	always_comb
	begin
		col_sum_next = '0;
		low_word_next = '0;

		case (pp_lane_size)
			lane64:
			begin
				// column k collects every product whose chunk indices add up to k
				// products above column 3 fall outside the low 64 bits
				for (int i = 0; i < num_chunks; i++)
				begin
					for (int j = 0; j < num_chunks; j++)
					begin
						if (i + j < num_chunks)
						begin
							col_sum_next[i + j] = col_sum_next[i + j]
								+ col_sum_t'(chunk_prod[i][j]);
						end
					end
				end
			end

			lane32:
			begin
				// lane 0 uses chunks 0 and 1 of each operand
				col_sum_next[0] = col_sum_t'(chunk_prod[0][0]);
				col_sum_next[1] = col_sum_t'(chunk_prod[1][0])
					+ col_sum_t'(chunk_prod[0][1]);

				// lane 1 uses chunks 2 and 3
				col_sum_next[2] = col_sum_t'(chunk_prod[2][2]);
				col_sum_next[3] = col_sum_t'(chunk_prod[3][2])
					+ col_sum_t'(chunk_prod[2][3]);
			end

			lane16:
			begin
				// diagonal products are the lane products
				for (int k = 0; k < num_chunks; k++)
				begin
					low_word_next[k * chunk_width +: chunk_width]
						= chunk_prod[k][k][chunk_width-1:0];
				end
			end

			lane8:
			begin
				low_word_next = byte_prod;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cs_valid <= 1'b0;
		end
		else
		begin
			cs_valid <= pp_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pp_valid)
		begin
			cs_lane_size <= pp_lane_size;
			col_sum <= col_sum_next;
			low_word <= low_word_next;
		end
	end

endmodule

// ==== src/result_assembly_stage.sv ====
`timescale 1ns/1ps

module result_assembly_stage
	import vmul_pkg::*;
(
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      cs_valid,
	input  lane_size_t                cs_lane_size,
	input  col_sum_t [num_chunks-1:0] col_sum,
	input  logic [data_width-1:0]     low_word,
	output logic                      result_valid,
	output logic [data_width-1:0]     result
);

	// full 64-bit product from the four columns
	logic [data_width-1:0] wide_sum;

	// the two 32-bit lanes
	logic [word_width-1:0] word_lo;
	logic [word_width-1:0] word_hi;

	logic [data_width-1:0] result_next;

	// weight k column lands at bit 16*k
	// bits shifted past bit 63 are dropped
	always_comb
	begin
		wide_sum = '0;
		for (int k = 0; k < num_chunks; k++)
		begin
			wide_sum = wide_sum
				+ (data_width'(col_sum[k]) << (k * chunk_width));
		end
	end

	// weight-1 sum carries into the upper half of each lane
	always_comb
	begin
		word_lo = word_width'(col_sum[0])
			+ (word_width'(col_sum[1]) << chunk_width);
		word_hi = word_width'(col_sum[2])
			+ (word_width'(col_sum[3]) << chunk_width);
	end

	always_comb
	begin
		case (cs_lane_size)
			lane64:
			begin
				result_next = wide_sum;
			end

			lane32:
			begin
				result_next = {word_hi, word_lo};
			end

			default:
			begin
				// lane16 and lane8 were packed in the previous stage
				result_next = low_word;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= cs_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cs_valid)
		begin
			result <= result_next;
		end
	end

endmodule

// ==== src/vector_mul_top.sv ====
`timescale 1ns/1ps

module vector_mul_top
	import vmul_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  lane_size_t            lane_size,
	output logic                  result_valid,
	output logic [data_width-1:0] result
);

	// stage 1 to stage 2
	logic                                         pp_valid;
	lane_size_t                                   pp_lane_size;
	chunk_prod_t [num_chunks-1:0][num_chunks-1:0] chunk_prod;
	logic [byte_lanes-1:0][byte_width-1:0]        byte_prod;

	// stage 2 to stage 3
	logic                      cs_valid;
	lane_size_t                cs_lane_size;
	col_sum_t [num_chunks-1:0] col_sum;
	logic [data_width-1:0]     low_word;

	// chunk and byte multipliers
	partial_product_stage partial_product_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.a            (a),
		.b            (b),
		.lane_size    (lane_size),
		.pp_valid     (pp_valid),
		.pp_lane_size (pp_lane_size),
		.chunk_prod   (chunk_prod),
		.byte_prod    (byte_prod)
	);

	// column sums per lane size
	column_sum_stage column_sum_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.pp_valid     (pp_valid),
		.pp_lane_size (pp_lane_size),
		.chunk_prod   (chunk_prod),
		.byte_prod    (byte_prod),
		.cs_valid     (cs_valid),
		.cs_lane_size (cs_lane_size),
		.col_sum      (col_sum),
		.low_word     (low_word)
	);

	// final shift, add and pack
	result_assembly_stage result_assembly_stage_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.cs_valid     (cs_valid),
		.cs_lane_size (cs_lane_size),
		.col_sum      (col_sum),
		.low_word     (low_word),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

// ==== tb/vector_mul_ref.svh ====
`ifndef VECTOR_MUL_REF_SVH
`define VECTOR_MUL_REF_SVH

// expected lane-wise product, each lane keeps the low half of its product
function automatic logic [63:0] expected_product(
	input logic [63:0] op_a,
	input logic [63:0] op_b,
	input lane_size_t  size
);
	int           width;
	logic [63:0]  mask;
	logic [63:0]  lane_a;
	logic [63:0]  lane_b;
	logic [127:0] full;
	logic [63:0]  prod_word;

	case (size)
		lane8:   width = 8;
		lane16:  width = 16;
		lane32:  width = 32;
		default: width = 64;
	endcase

	if (width == 64)
	begin
		mask = '1;
	end
	else
	begin
		mask = (64'd1 << width) - 64'd1;
	end

	prod_word = '0;
	for (int l = 0; l < 64 / width; l++)
	begin
		lane_a = (op_a >> (l * width)) & mask;
		lane_b = (op_b >> (l * width)) & mask;
		// full width product, then cut back to the lane
		full = lane_a * lane_b;
		prod_word = prod_word | ((full[63:0] & mask) << (l * width));
	end

	return prod_word;
endfunction

`endif

// ==== tb/vector_mul_tb.sv ====
`timescale 1ns/1ps

module vector_mul_tb
	import vmul_pkg::*;
();

	localparam int clk_period = 8;
	localparam int reset_cycles = 3;
	localparam int num_random = 20;
	localparam int num_directed = 6;
	localparam int b2b_ops = 200;
	localparam int sparse_ops = 60;
	localparam int max_gap = 5;
	localparam int total_ops = 4 * num_random + num_directed + b2b_ops + sparse_ops;

	// sparse gaps and drains go into the margin
	localparam int margin_ns = (sparse_ops * max_gap + 200) * clk_period;
	localparam int watchdog_ns = total_ops * clk_period + reset_cycles * clk_period + margin_ns;

	logic                  clk;
	logic                  arst_n;
	logic                  start;
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	lane_size_t            lane_size;
	logic                  result_valid;
	logic [data_width-1:0] result;

	integer seed = 21;
	int     edge_count = 0;
	int     issued_count = 0;
	int     checked_count = 0;
	string  current_test = "reset";

	// outstanding operations, oldest first
	logic [data_width-1:0] exp_q[$];
	int                    edge_q[$];
	string                 name_q[$];

	`include "vector_mul_ref.svh"

	vector_mul_top dut_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.a            (a),
		.b            (b),
		.lane_size    (lane_size),
		.result_valid (result_valid),
		.result       (result)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk)
	begin
		edge_count <= edge_count + 1;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(
		input string                 name,
		input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual
	);
		if (actual !== expected)
		begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	function automatic logic [data_width-1:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// one strobe and the edge that samples it
	task automatic drive_op(
		input logic [data_width-1:0] op_a,
		input logic [data_width-1:0] op_b,
		input lane_size_t            size
	);
		a <= op_a;
		b <= op_b;
		lane_size <= size;
		start <= 1'b1;
		@(posedge clk);
	endtask

	task automatic run_random(input string name, input lane_size_t size, input int count);
		logic [data_width-1:0] op_a;
		logic [data_width-1:0] op_b;

		current_test = name;
		repeat (count)
		begin
			op_a = random_word();
			op_b = random_word();
			drive_op(op_a, op_b, size);
		end
	endtask

	// results are due latency cycles after the last strobe
	task automatic drain(input string name);
		start <= 1'b0;
		repeat (latency + 2) @(posedge clk);
		if (exp_q.size() != 0)
		begin
			fail_run($sformatf("%s: %0d results never appeared", name, exp_q.size()));
		end
	endtask

	// results are compared on the falling edge
	// a strobe is recorded with the edge that started its cycle
	always @(negedge clk)
	begin
		if (result_valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				fail_run("result_valid went high with no operation outstanding");
			end
			else
			begin
				check_value(name_q[0], exp_q[0], result);
				check_value({name_q[0], " latency"}, latency, edge_count - edge_q[0]);
				void'(exp_q.pop_front());
				void'(edge_q.pop_front());
				void'(name_q.pop_front());
				checked_count++;
			end
		end
		if (start === 1'b1 && arst_n === 1'b1)
		begin
			exp_q.push_back(expected_product(a, b, lane_size));
			edge_q.push_back(edge_count);
			name_q.push_back(current_test);
			issued_count++;
		end
	end

	initial
	begin
		#(watchdog_ns);
		fail_run("timeout: the tests did not finish in time");
	end

	initial
	begin
		logic [31:0] rnd;
		int          gap;

		arst_n <= 1'b0;
		start <= 1'b0;
		a <= '0;
		b <= '0;
		lane_size <= lane8;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;

		// nothing comes out while start stays low
		current_test = "idle";
		repeat (10)
		begin
			@(negedge clk);
			check_value("idle", '0, result_valid);
		end
		@(posedge clk);

		run_random("lane8 random", lane8, num_random);
		current_test = "lane8 directed";
		drive_op('1, '1, lane8);
		drive_op(64'h0102_0304_ff80_7f10, 64'hff02_0304_ff80_0210, lane8);
		drain("lane8");

		run_random("lane16 random", lane16, num_random);
		current_test = "lane16 all ones";
		drive_op('1, '1, lane16);
		drain("lane16");

		run_random("lane32 random", lane32, num_random);
		current_test = "lane32 all ones";
		drive_op('1, '1, lane32);
		drain("lane32");

		run_random("lane64 random", lane64, num_random);
		current_test = "lane64 directed";
		drive_op('1, '1, lane64);
		drive_op(64'h0000_0001_0000_ffff, 64'hffff_0000_ffff_0001, lane64);
		drain("lane64");

		// start held high with a new lane size every cycle
		current_test = "back to back";
		repeat (b2b_ops)
		begin
			rnd = $random(seed);
			drive_op(random_word(), random_word(), lane_size_t'(rnd[1:0]));
		end
		drain("back to back");

		current_test = "sparse";
		repeat (sparse_ops)
		begin
			rnd = $random(seed);
			drive_op(random_word(), random_word(), lane_size_t'(rnd[1:0]));
			gap = 1 + ($unsigned($random(seed)) % max_gap);
			start <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		drain("sparse");

		if (issued_count == total_ops && checked_count == issued_count)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			fail_run($sformatf("%0d operations issued, %0d results checked, %0d planned",
				issued_count, checked_count, total_ops));
		end
	end

endmodule

// ==== filelist.f ====
+incdir+tb
src/vmul_pkg.sv
src/partial_product_stage.sv
src/column_sum_stage.sv
src/result_assembly_stage.sv
src/vector_mul_top.sv
tb/vector_mul_tb.sv
